//--- verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int data_bits  = 8;
  localparam int cmd_width  = 16;
  localparam int frame_bits = 11;  // start, 8 data, parity, stop

  typedef struct packed {
    logic [7:0] hi_byte;  // sent first
    logic [7:0] lo_byte;
  } cmd_bytes_t;

  typedef struct packed {
    logic       rw;    // 1 is write, 0 is read
    logic [6:0] addr;
    logic [7:0] data;  // don't care for a read
  } cmd_fields_t;

  typedef union packed {
    cmd_bytes_t  bytes;
    cmd_fields_t fields;
  } cmd_word_t;

  // parity bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [data_bits-1:0] d);
    logic p;
    p = ~(^d);
    return p;
  endfunction

endpackage

//--- verilog/uart_tx.sv
module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               tx_start,
  input  logic [uart_cmd_pkg::data_bits-1:0] tx_data,
  output logic                               tx,
  output logic                               tx_done
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int idx_w = $clog2(uart_cmd_pkg::frame_bits);
  localparam int shr_w = uart_cmd_pkg::frame_bits - 1;

  logic             busy;
  logic [cnt_w-1:0] baud_cnt;
  logic [idx_w-1:0] bit_idx;
  logic [shr_w-1:0] shreg;  // bits still to go out after the start bit
  logic             bit_end;
  logic             last_bit;

  assign bit_end  = (baud_cnt == cnt_w'(clks_per_bit - 1));
  assign last_bit = (bit_idx == idx_w'(uart_cmd_pkg::frame_bits - 1));
  assign tx_done  = busy && bit_end && last_bit;  // last cycle of the stop bit

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
        tx       <= 1'b0;  // start bit
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;  // line is already high from the stop bit
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // shifted LSB first, ones fill in behind so the stop bit falls out last
  always_ff @(posedge clk)
  begin
    if (tx_start && !busy)
    begin
      shreg <= {1'b1, uart_cmd_pkg::odd_parity(tx_data), tx_data};
    end
    else if (busy && bit_end)
    begin
      shreg <= {1'b1, shreg[shr_w-1:1]};
    end
  end

endmodule

//--- verilog/uart_rx.sv
module uart_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               rx,
  output logic [uart_cmd_pkg::data_bits-1:0] rx_data,
  output logic                               rx_done,
  output logic                               rx_err,
  output logic                               rx_busy
);

  localparam int cnt_w    = $clog2(clks_per_bit);
  localparam int idx_w    = $clog2(uart_cmd_pkg::frame_bits);
  localparam int half_bit = clks_per_bit / 2;
  localparam int sync_lag = 2;  // edge is seen two clocks late
  localparam int par_idx  = uart_cmd_pkg::data_bits + 1;
  localparam int stop_idx = uart_cmd_pkg::frame_bits - 1;

  logic [2:0]                         rx_sync;
  logic                               rx_s;
  logic                               fall;
  logic                               busy;
  logic [cnt_w-1:0]                   baud_cnt;
  logic [idx_w-1:0]                   bit_idx;
  logic                               mid;
  logic                               bit_end;
  logic [uart_cmd_pkg::data_bits-1:0] shreg;
  logic                               par_bit;

  assign rx_s    = rx_sync[1];
  assign fall    = rx_sync[2] & ~rx_sync[1];
  assign mid     = (baud_cnt == cnt_w'(half_bit));
  assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));
  assign rx_data = shreg;
  assign rx_busy = busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sync <= '1;  // idle line is high
    else
      rx_sync <= {rx_sync[1:0], rx};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
      rx_err   <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      rx_err  <= 1'b0;
      if (!busy)
      begin
        if (fall)
        begin
          busy     <= 1'b1;
          baud_cnt <= cnt_w'(sync_lag);
          bit_idx  <= '0;
        end
      end
      else
      begin
        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
        if (mid)
        begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == '0 && rx_s)
          begin
            busy <= 1'b0;  // glitch, back to hunting
          end
          else if (bit_idx == idx_w'(stop_idx))
          begin
            busy    <= 1'b0;
            rx_done <= 1'b1;
            rx_err  <= (par_bit != uart_cmd_pkg::odd_parity(shreg)) || !rx_s;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (busy && mid)
    begin
      if (bit_idx >= idx_w'(1) && bit_idx <= idx_w'(uart_cmd_pkg::data_bits))
        shreg <= {rx_s, shreg[uart_cmd_pkg::data_bits-1:1]};  // LSB arrives first
      if (bit_idx == idx_w'(par_idx))
        par_bit <= rx_s;
    end
  end

endmodule

//--- verilog/uart_cmd_ctrl.sv
module uart_cmd_ctrl #(
  parameter int gap_cycles    = 100,
  parameter int reply_timeout = 26040
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic [uart_cmd_pkg::data_bits-1:0] read_data,
  output logic                               read_vld,
  output logic                               read_err,
  output logic                               tx_start,
  output logic [uart_cmd_pkg::data_bits-1:0] tx_data,
  input  logic                               tx_done,
  input  logic [uart_cmd_pkg::data_bits-1:0] rx_data,
  input  logic                               rx_done,
  input  logic                               rx_err,
  input  logic                               rx_busy
);

  localparam logic [2:0] s_idle       = 3'd0;
  localparam logic [2:0] s_send_hi    = 3'd1;
  localparam logic [2:0] s_gap        = 3'd2;
  localparam logic [2:0] s_send_lo    = 3'd3;
  localparam logic [2:0] s_wait_reply = 3'd4;

  localparam int cnt_max = (reply_timeout > gap_cycles) ? reply_timeout : gap_cycles;
  localparam int cnt_w   = $clog2(cnt_max + 1);

  logic [2:0]              state;
  logic [cnt_w-1:0]        cnt;  // shared by the gap and the reply timeout
  uart_cmd_pkg::cmd_word_t cmd_next;
  uart_cmd_pkg::cmd_word_t cmd_q;
  logic                    accept;
  logic                    gap_end;
  logic                    timeout;

  assign cmd_next = cmd_in;
  assign accept   = (state == s_idle) && cmd_vld && cmd_rdy;
  assign gap_end  = (cnt == cnt_w'(gap_cycles - 1));
  assign timeout  = (cnt == cnt_w'(reply_timeout - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= s_idle;
      cnt      <= '0;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      read_err <= 1'b0;
      case (state)
        s_idle:
        begin
          if (!cmd_rdy)
          begin
            cmd_rdy <= 1'b1;  // one cycle after a read result
          end
          else if (accept)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= s_send_hi;
          end
        end
        s_send_hi:
        begin
          if (tx_done)
          begin
            cnt   <= '0;
            state <= s_gap;
          end
        end
        s_gap:
        begin
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= s_send_lo;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        s_send_lo:
        begin
          if (tx_done && cmd_q.fields.rw)
          begin
            cmd_rdy <= 1'b1;  // writes expect no reply
            state   <= s_idle;
          end
          else if (tx_done)
          begin
            cnt   <= '0;
            state <= s_wait_reply;
          end
        end
        s_wait_reply:
        begin
          if (rx_done)
          begin
            read_vld <= !rx_err;
            read_err <= rx_err;
            state    <= s_idle;
          end
          else if (timeout && !rx_busy)
          begin
            read_err <= 1'b1;
            state    <= s_idle;
          end
          else if (!rx_busy)
          begin
            cnt <= cnt + 1'b1;  // held while a frame is coming in
          end
        end
        default:
        begin
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_next;
      tx_data <= cmd_next.bytes.hi_byte;
    end
    else if (state == s_gap && gap_end)
    begin
      tx_data <= cmd_q.bytes.lo_byte;
    end
    if (state == s_wait_reply && rx_done && !rx_err)
      read_data <= rx_data;
  end

endmodule

//--- verilog/uart_cmd_top.sv
module uart_cmd_top #(
  parameter int clks_per_bit  = 434,
  parameter int gap_cycles    = 100,
  parameter int reply_timeout = 60 * 434
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic [uart_cmd_pkg::data_bits-1:0] read_data,
  output logic                               read_vld,
  output logic                               read_err,
  output logic                               tx,
  input  logic                               rx
);

  logic                               tx_start;
  logic [uart_cmd_pkg::data_bits-1:0] tx_data;
  logic                               tx_done;
  logic [uart_cmd_pkg::data_bits-1:0] rx_data;
  logic                               rx_done;
  logic                               rx_err;
  logic                               rx_busy;

  uart_cmd_ctrl #(
    .gap_cycles    (gap_cycles),
    .reply_timeout (reply_timeout)
  ) i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_err  (read_err),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .tx_done   (tx_done),
    .rx_data   (rx_data),
    .rx_done   (rx_done),
    .rx_err    (rx_err),
    .rx_busy   (rx_busy)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) i_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_data (rx_data),
    .rx_done (rx_done),
    .rx_err  (rx_err),
    .rx_busy (rx_busy)
  );

endmodule

//--- verification/uart_line_model.sv
module uart_line_model #(
  parameter int clks_per_bit = 16
) (
  input  logic clk,
  input  logic tx,
  output logic rx
);

  localparam int max_frames = 64;

  logic [7:0] frame_data [max_frames];
  logic       parity_ok [max_frames];
  logic       stop_ok [max_frames];
  int         frame_count;
  logic [7:0] shift;
  logic       par;
  logic       stop;

  initial
  begin
    rx = 1'b1;  // idle line
    frame_count = 0;
  end

  // tx moves on rising edges, so the falling edge is a quiet place to look at it
  always @(negedge clk)
  begin
    if (tx === 1'b0)
    begin
      repeat (clks_per_bit / 2) @(negedge clk);
      if (tx === 1'b0)
      begin
        for (int i = 0; i < 8; i++)
        begin
          repeat (clks_per_bit) @(negedge clk);
          shift[i] = tx;  // LSB first
        end
        repeat (clks_per_bit) @(negedge clk);
        par = tx;
        repeat (clks_per_bit) @(negedge clk);
        stop = tx;
        if (frame_count < max_frames)
        begin
          frame_data[frame_count] = shift;
          parity_ok[frame_count]  = ((^{shift, par}) === 1'b1);  // odd count of ones over 9 bits
          stop_ok[frame_count]    = (stop === 1'b1);
        end
        frame_count = frame_count + 1;
      end
    end
  end

  // drives one reply frame on rx with the parity optionally flipped
  task automatic send_reply(input logic [7:0] value, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, uart_cmd_pkg::odd_parity(value) ^ bad_parity, value, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rx <= frame[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
  endtask

endmodule

//--- verification/uart_cmd_tb.sv
module uart_cmd_tb;

  localparam int clks_per_bit  = 16;
  localparam int gap_cycles    = 20;
  localparam int reply_timeout = 60 * clks_per_bit;
  localparam int frame_cycles  = 11 * clks_per_bit;
  localparam int cmd_limit     = 2 * frame_cycles + gap_cycles + 100;
  localparam int result_limit  = reply_timeout + 2 * frame_cycles + gap_cycles + 200;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic [7:0]  read_data;
  logic        read_vld;
  logic        read_err;
  logic        tx;
  logic        rx;
  int          value_errors = 0;
  int          timeouts = 0;
  int          vld_count = 0;
  int          err_count = 0;
  logic [7:0]  last_read;
  integer      seed;

  uart_cmd_top #(
    .clks_per_bit  (clks_per_bit),
    .gap_cycles    (gap_cycles),
    .reply_timeout (reply_timeout)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_err  (read_err),
    .tx        (tx),
    .rx        (rx)
  );

  uart_line_model #(
    .clks_per_bit (clks_per_bit)
  ) i_model (
    .clk (clk),
    .tx  (tx),
    .rx  (rx)
  );

  always #4 clk = ~clk;

  // read_vld and read_err can pulse while a reply is still going out on rx
  always @(posedge clk)
  begin
    if (read_vld)
    begin
      vld_count <= vld_count + 1;
      last_read <= read_data;
    end
    if (read_err)
      err_count <= err_count + 1;
  end

  task automatic report_value(input string name, input string what, input int expected,
                              input int actual);
    value_errors++;
    $display("Error %s: %s expected %0h, actual %0h", name, what, expected, actual);
  endtask

  task automatic report_timeout(input string name, input string what);
    timeouts++;
    $display("%s: timed out waiting for %s", name, what);
  endtask

  task automatic send_cmd(input string name, input logic [15:0] word);
    if (cmd_rdy !== 1'b1)
      report_value(name, "cmd_rdy before command", 1, cmd_rdy);
    @(posedge clk);
    cmd_in  <= word;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    @(posedge clk);
    while (cmd_rdy !== 1'b1 && n < result_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
      report_timeout(name, "cmd_rdy to return high");
  endtask

  task automatic wait_frames(input string name, input int target);
    int n;
    n = 0;
    while (i_model.frame_count < target && n < cmd_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (i_model.frame_count < target)
      report_timeout(name, "the command frames on tx");
  endtask

  task automatic wait_result(input string name, input int base);
    int n;
    n = 0;
    while (vld_count + err_count == base && n < result_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (vld_count + err_count == base)
      report_timeout(name, "a read_vld or read_err pulse");
  endtask

  task automatic check_frames(input string name, input int base, input logic [15:0] word);
    logic [7:0] expected [2];
    expected[0] = word[15:8];  // upper byte goes out first
    expected[1] = word[7:0];
    if (i_model.frame_count != base + 2)
      report_value(name, "frame count", base + 2, i_model.frame_count);
    else
    begin
      for (int k = 0; k < 2; k++)
      begin
        if (i_model.frame_data[base + k] !== expected[k])
          report_value(name, "frame byte", expected[k], i_model.frame_data[base + k]);
        if (i_model.parity_ok[base + k] !== 1'b1)
          report_value(name, "frame parity ok", 1, i_model.parity_ok[base + k]);
        if (i_model.stop_ok[base + k] !== 1'b1)
          report_value(name, "frame stop ok", 1, i_model.stop_ok[base + k]);
      end
    end
  endtask

  task automatic write_command(input string name, input logic [15:0] word);
    int base_f;
    int base_v;
    int base_e;
    base_f = i_model.frame_count;
    base_v = vld_count;
    base_e = err_count;
    send_cmd(name, word);
    wait_ready(name);
    repeat (2) @(posedge clk);
    check_frames(name, base_f, word);
    if (vld_count != base_v)
      report_value(name, "read_vld pulses", 0, vld_count - base_v);
    if (err_count != base_e)
      report_value(name, "read_err pulses", 0, err_count - base_e);
  endtask

  task automatic read_command(input string name, input logic [15:0] word, input logic [7:0] reply,
                              input logic do_reply, input logic bad_parity);
    int base_f;
    int base_v;
    int base_e;
    base_f = i_model.frame_count;
    base_v = vld_count;
    base_e = err_count;
    send_cmd(name, word);
    wait_frames(name, base_f + 2);
    if (do_reply)
    begin
      repeat (2 * clks_per_bit) @(posedge clk);  // let the DUT open its reply window
      i_model.send_reply(reply, bad_parity);
    end
    wait_result(name, base_v + base_e);
    wait_ready(name);
    repeat (4) @(posedge clk);
    check_frames(name, base_f, word);
    if (i_model.frame_count > base_f && i_model.frame_data[base_f][7] !== 1'b0)
      report_value(name, "read bit of first byte", 0, i_model.frame_data[base_f][7]);
    if (do_reply && !bad_parity)
    begin
      if (vld_count - base_v != 1)
        report_value(name, "read_vld pulses", 1, vld_count - base_v);
      if (err_count != base_e)
        report_value(name, "read_err pulses", 0, err_count - base_e);
      if (last_read !== reply)
        report_value(name, "read_data", reply, last_read);
    end
    else
    begin
      if (err_count - base_e != 1)
        report_value(name, "read_err pulses", 1, err_count - base_e);
      if (vld_count != base_v)
        report_value(name, "read_vld pulses", 0, vld_count - base_v);
    end
  endtask

  task automatic reset_and_write();
    if (tx !== 1'b1)
      report_value("reset", "tx", 1, tx);
    if (cmd_rdy !== 1'b1)
      report_value("reset", "cmd_rdy", 1, cmd_rdy);
    if (read_vld !== 1'b0 || read_err !== 1'b0)
      report_value("reset", "read_vld and read_err", 0, {read_vld, read_err});
    write_command("write", 16'hA53C);
  endtask

  task automatic read_good_reply();
    logic [7:0] reply;
    reply = $random(seed);
    read_command("read_good", 16'h2A00, reply, 1'b1, 1'b0);
  endtask

  task automatic read_bad_parity();
    read_command("read_bad_parity", 16'h1100, 8'h5E, 1'b1, 1'b1);
  endtask

  task automatic read_no_reply();
    read_command("read_no_reply", 16'h7F00, 8'h00, 1'b0, 1'b0);
  endtask

  task automatic busy_command_ignored();
    int base_f;
    base_f = i_model.frame_count;
    send_cmd("busy", 16'hC3A5);
    repeat (clks_per_bit) @(posedge clk);
    if (cmd_rdy !== 1'b0)
      report_value("busy", "cmd_rdy while busy", 0, cmd_rdy);
    cmd_in  <= 16'h8E71;  // must be dropped
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    wait_ready("busy");
    repeat (frame_cycles) @(posedge clk);
    check_frames("busy", base_f, 16'hC3A5);
  endtask

  task automatic random_sequence();
    logic [15:0] word;
    logic [7:0]  reply;
    for (int k = 0; k < 8; k++)
    begin
      word  = $random(seed);
      reply = $random(seed);
      if (word[15])
        write_command("random", word);
      else
        read_command("random", word, reply, 1'b1, 1'b0);
    end
  endtask

  initial
  begin
    seed    = 32'h60ce536d;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_and_write();
    read_good_reply();
    read_bad_parity();
    read_no_reply();
    busy_command_ignored();
    random_sequence();
    $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- list.f
verilog/uart_cmd_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_cmd_top.sv
verification/uart_line_model.sv
verification/uart_cmd_tb.sv

//--- Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - files:
      - verilog/uart_cmd_pkg.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_cmd_ctrl.sv
      - verilog/uart_cmd_top.sv
  - target: test
    files:
      - verification/uart_line_model.sv
      - verification/uart_cmd_tb.sv
